//--- ltssmPkg.sv
`default_nettype none

package ltssmPkg;

	// Training state codes, shared with the main LTSSM
	typedef enum logic [4:0] {
		DetectQuiet           = 5'd0,
		DetectActive          = 5'd1,
		PollingActive         = 5'd2,
		PollingConfiguration  = 5'd3,
		ConfigLinkWidthStart  = 5'd4,
		ConfigLinkWidthAccept = 5'd5,
		ConfigLaneNumWait     = 5'd6,
		ConfigLaneNumActive   = 5'd7,
		ConfigComplete        = 5'd8,
		ConfigIdle            = 5'd9,
		L0                    = 5'd10,
		RecoveryRcvrLock      = 5'd11,
		RecoveryRcvrCfg       = 5'd12,
		RecoveryIdle          = 5'd18,
		IdleHold              = 5'd31   // Reset state
	} txStateT;

	// Ordered-set kinds understood by the generator
	typedef enum logic [2:0] {
		Ts1    = 3'd0,
		Ts2    = 3'd1,
		IdleOs = 3'd4
	} osTypeT;

	typedef logic [7:0]  linkNumT;
	typedef logic [1:0]  laneNumT;   // Lane-number field code
	typedef logic [15:0] osCountT;
	typedef logic [2:0]  genT;       // Generation / rate code

	// Lane-number field codes
	localparam laneNumT LanePad    = 2'd0;
	localparam laneNumT LaneNumSeq = 2'd1;

	// Link number before assignment
	localparam linkNumT PadLinkNum        = 8'd0;
	localparam linkNumT DownstreamLinkNum = 8'd1;

	// Ordered sets needed to leave a state
	localparam osCountT PollingCfgOsCount     = 16'd16;  // TS2
	localparam osCountT ConfigCompleteOsCount = 16'd16;  // TS2
	localparam osCountT ConfigIdleOsCount     = 16'd7;   // Idle after startSend16
	localparam osCountT RecoveryIdleOsCount   = 16'd6;   // Idle

endpackage

`default_nettype wire

//--- ltssmCtrlIf.sv
`timescale 1ns/1ns
`default_nettype none

interface ltssmCtrlIf import ltssmPkg::*; ();

	txStateT state;      // Registered training state
	logic    entered;    // High in first cycle of a new state
	osCountT osCount;    // Finished ordered sets in this state
	osCountT idleCount;  // Idle finishes after startSend16
	logic    timeOut;    // Detect interval expired

	modport tracker (
		output state, entered,
		input  osCount, idleCount, timeOut
	);

	modport counter (
		output osCount, idleCount,
		input  state, entered
	);

	modport timer (
		output timeOut,
		input  state, entered
	);

	modport requester (
		input state, entered, osCount, idleCount, timeOut
	);

endinterface

`default_nettype wire

//--- intervalTimer.sv
`timescale 1ns/1ns
`default_nettype none

module intervalTimer import ltssmPkg::*; #(
	parameter int DetectTimeoutCycles = 60
) (
	input logic Pclk,
	input logic rstN,
	ltssmCtrlIf.timer ctrl
);

	localparam int CountW = $clog2(DetectTimeoutCycles + 1);

	logic [CountW-1:0] remaining;
	logic running;
	logic inDetect;

	assign inDetect = (ctrl.state == DetectQuiet) || (ctrl.state == DetectActive);

	always_ff @(posedge Pclk) begin
		if (!rstN) begin
			remaining <= '0;
			running <= 1'b0;
			ctrl.timeOut <= 1'b0;
		end else begin
			ctrl.timeOut <= 1'b0;
			if (ctrl.entered && inDetect) begin
				remaining <= CountW'(DetectTimeoutCycles);  // Reload on each detect entry
				running <= 1'b1;
			end else if (!inDetect) begin
				running <= 1'b0;
			end else if (running) begin
				remaining <= remaining - 1'b1;
				if (remaining == CountW'(1)) begin
					running <= 1'b0;  // One shot per entry
					ctrl.timeOut <= 1'b1;
				end
			end
		end
	end

	// Main LTSSM sees one expiry per interval
	timeOutSingle: assert property (@(posedge Pclk) disable iff (!rstN)
		ctrl.timeOut |=> !ctrl.timeOut);

endmodule

`default_nettype wire

//--- osCounter.sv
`timescale 1ns/1ns
`default_nettype none

module osCounter import ltssmPkg::*; (
	input logic Pclk,
	input logic rstN,
	input logic OSGeneratorFinish,
	input logic startSend16,
	ltssmCtrlIf.counter ctrl
);

	logic idleArmed;     // startSend16 seen in this ConfigIdle visit
	logic inConfigIdle;
	logic osFull;
	logic idleFull;

	assign inConfigIdle = ctrl.state == ConfigIdle;

	// Saturate instead of wrapping in states with no exit count
	assign osFull = &ctrl.osCount;
	assign idleFull = &ctrl.idleCount;

	always_ff @(posedge Pclk) begin
		if (!rstN) begin
			ctrl.osCount <= '0;
			ctrl.idleCount <= '0;
			idleArmed <= 1'b0;
		end else if (ctrl.entered) begin
			ctrl.osCount <= '0;
			ctrl.idleCount <= '0;
			idleArmed <= inConfigIdle && startSend16;
		end else begin
			if (OSGeneratorFinish && !osFull) begin
				ctrl.osCount <= ctrl.osCount + 1'b1;
			end
			if (inConfigIdle && startSend16) begin
				idleArmed <= 1'b1;
			end
			// Only finishes after arming count toward the idle exit
			if (inConfigIdle && idleArmed && OSGeneratorFinish && !idleFull) begin
				ctrl.idleCount <= ctrl.idleCount + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- stateTracker.sv
`timescale 1ns/1ns
`default_nettype none

module stateTracker import ltssmPkg::*; #(
	parameter int LaneCount = 16,
	parameter int PollingActiveOsCount = 1024
) (
	input  logic                 Pclk,
	input  logic                 rstN,
	input  txStateT              SetTXState,
	input  logic [LaneCount-1:0] DetectStatus,
	input  logic                 OSGeneratorFinish,
	ltssmCtrlIf.tracker          ctrl,
	output logic                 TXFinishFlag,
	output txStateT              TXExitTo,
	output logic [LaneCount-1:0] DetectLanes,
	output logic [4:0]           NumberDetectLanes,
	output logic                 WriteDetectLanesFlag
);

	logic exitFlag;
	txStateT exitState;
	logic captureLanes;   // Detect exit toward polling
	logic lanesWritten;
	logic allDetected;
	logic anyDetected;

	assign allDetected = &DetectStatus;
	assign anyDetected = |DetectStatus;

	// State follows the main LTSSM one cycle later
	always_ff @(posedge Pclk) begin
		if (!rstN) begin
			ctrl.state <= IdleHold;
			ctrl.entered <= 1'b0;
		end else begin
			ctrl.state <= SetTXState;
			ctrl.entered <= SetTXState != ctrl.state;
		end
	end

	// Exit rules, held off in the entry cycle while counts clear
	always_comb begin
		exitFlag = 1'b0;
		exitState = DetectQuiet;
		captureLanes = 1'b0;
		if (!ctrl.entered) begin
			case (ctrl.state)
				DetectQuiet: begin
					exitFlag = ctrl.timeOut;
					exitState = DetectActive;
				end
				DetectActive: begin
					if (allDetected || (ctrl.timeOut && anyDetected)) begin
						exitFlag = 1'b1;
						exitState = PollingActive;
						captureLanes = 1'b1;
					end else if (ctrl.timeOut) begin
						exitFlag = 1'b1;  // Nothing found, back to quiet
						exitState = DetectQuiet;
					end
				end
				PollingActive: begin
					exitFlag = ctrl.osCount >= osCountT'(PollingActiveOsCount);
					exitState = PollingConfiguration;
				end
				PollingConfiguration: begin
					exitFlag = ctrl.osCount >= PollingCfgOsCount;
					exitState = ConfigLinkWidthStart;
				end
				ConfigLinkWidthAccept: begin
					exitFlag = OSGeneratorFinish;
					exitState = ConfigLaneNumWait;
				end
				ConfigComplete: begin
					exitFlag = ctrl.osCount >= ConfigCompleteOsCount;
					exitState = ConfigIdle;
				end
				ConfigIdle: begin
					exitFlag = ctrl.idleCount >= ConfigIdleOsCount;
					exitState = L0;
				end
				RecoveryRcvrLock: begin
					exitFlag = OSGeneratorFinish;
					exitState = RecoveryRcvrCfg;
				end
				RecoveryRcvrCfg: begin
					exitFlag = OSGeneratorFinish;
					exitState = RecoveryIdle;
				end
				RecoveryIdle: begin
					exitFlag = ctrl.osCount >= RecoveryIdleOsCount;
					exitState = L0;
				end
				default: exitFlag = 1'b0;  // Stay until SetTXState moves
			endcase
		end
	end

	always_ff @(posedge Pclk) begin
		if (!rstN) begin
			TXFinishFlag <= 1'b0;
			TXExitTo <= DetectQuiet;
			DetectLanes <= '0;
			WriteDetectLanesFlag <= 1'b0;
			lanesWritten <= 1'b0;
		end else begin
			TXFinishFlag <= exitFlag;
			TXExitTo <= exitState;
			WriteDetectLanesFlag <= captureLanes && !lanesWritten;
			if (captureLanes && !lanesWritten) begin
				DetectLanes <= DetectStatus;
			end
			if (ctrl.entered) begin
				lanesWritten <= 1'b0;
			end else if (captureLanes) begin
				lanesWritten <= 1'b1;  // One write per detect exit
			end
		end
	end

	// Highest set lane plus one
	always_comb begin
		NumberDetectLanes = '0;
		for (int i = 0; i < LaneCount; i++) begin
			if (DetectLanes[i]) begin
				NumberDetectLanes = 5'(i + 1);
			end
		end
	end

	finishHasTarget: assert property (@(posedge Pclk) disable iff (!rstN)
		TXFinishFlag |-> TXExitTo != IdleHold);

endmodule

`default_nettype wire

//--- osRequester.sv
`timescale 1ns/1ns
`default_nettype none

module osRequester import ltssmPkg::*; #(
	parameter int  LaneCount = 16,
	parameter bit  IsUpstream = 1'b0,
	parameter genT MaxGen = 3'd1
) (
	input  logic                 Pclk,
	input  logic                 rstN,
	input  linkNumT              ReadLinkNum,
	input  logic                 OSGeneratorBusy,
	ltssmCtrlIf.requester        ctrl,
	output osTypeT               OSType,
	output linkNumT              LinkNumber,
	output laneNumT              LaneNumber,
	output genT                  Rate,
	output logic                 OSGeneratorStart,
	output linkNumT              WriteLinkNum,
	output logic                 WriteLinkNumFlag,
	output logic                 HoldFIFOData,
	output logic                 MuxSel,
	output logic                 ScramblerOff,
	output logic [LaneCount-1:0] DetectReq,
	output logic [LaneCount-1:0] ElecIdleReq
);

	logic sendOs;      // State sends ordered sets
	osTypeT osKind;
	linkNumT linkSel;
	laneNumT laneSel;
	logic issue;
	logic linkWrite;
	logic scrTarget;
	logic scrStage;    // First stage of the scrambler delay

	// Ordered set contents per state
	always_comb begin
		sendOs = 1'b1;
		osKind = Ts1;
		linkSel = ReadLinkNum;
		laneSel = LaneNumSeq;
		case (ctrl.state)
			PollingActive: begin
				linkSel = PadLinkNum;
				laneSel = LanePad;
			end
			PollingConfiguration: begin
				osKind = Ts2;
				linkSel = PadLinkNum;
				laneSel = LanePad;
			end
			ConfigLinkWidthStart: begin
				linkSel = IsUpstream ? PadLinkNum : DownstreamLinkNum;
				laneSel = LanePad;
			end
			ConfigLinkWidthAccept: laneSel = IsUpstream ? LanePad : LaneNumSeq;
			ConfigLaneNumWait, ConfigLaneNumActive, RecoveryRcvrLock: osKind = Ts1;
			ConfigComplete, RecoveryRcvrCfg: osKind = Ts2;
			ConfigIdle, RecoveryIdle: osKind = IdleOs;
			default: sendOs = 1'b0;  // Detect, L0, IdleHold
		endcase
	end

	always_comb begin
		case (ctrl.state)
			DetectQuiet, DetectActive, PollingActive, PollingConfiguration,
			ConfigLinkWidthStart, ConfigLinkWidthAccept, ConfigLaneNumWait,
			ConfigLaneNumActive, ConfigComplete: scrTarget = 1'b1;
			ConfigIdle, L0: scrTarget = 1'b0;
			default: scrTarget = scrStage;  // Recovery keeps last setting
		endcase
	end

	// Never two starts back to back, busy only shows a cycle after start
	assign issue = sendOs && !OSGeneratorBusy && !OSGeneratorStart;

	// Downstream port assigns the link number once per entry
	assign linkWrite = ctrl.entered && (ctrl.state == ConfigLinkWidthStart) && !IsUpstream;

	always_ff @(posedge Pclk) begin
		if (!rstN) begin
			OSGeneratorStart <= 1'b0;
			WriteLinkNumFlag <= 1'b0;
			WriteLinkNum <= PadLinkNum;
			HoldFIFOData <= 1'b1;
			MuxSel <= 1'b0;
			scrStage <= 1'b1;
			ScramblerOff <= 1'b1;
			DetectReq <= '0;
			ElecIdleReq <= '0;
		end else begin
			OSGeneratorStart <= issue;
			WriteLinkNumFlag <= linkWrite;
			if (linkWrite) begin
				WriteLinkNum <= DownstreamLinkNum;
			end
			HoldFIFOData <= ctrl.state != L0;  // Data path only in L0
			MuxSel <= ctrl.state == L0;
			scrStage <= scrTarget;
			ScramblerOff <= scrStage;
			DetectReq <= {LaneCount{ctrl.state == DetectActive}};
			ElecIdleReq <= {LaneCount{(ctrl.state == DetectQuiet) ||
				(ctrl.state == RecoveryIdle)}};
		end
	end

	// Fields valid from the start cycle onward
	always_ff @(posedge Pclk) begin
		if (issue) begin
			OSType <= osKind;
			LinkNumber <= linkSel;
			LaneNumber <= laneSel;
			Rate <= MaxGen;
		end
	end

	startWhenFree: assert property (@(posedge Pclk) disable iff (!rstN)
		OSGeneratorStart |-> !OSGeneratorBusy);

endmodule

`default_nettype wire

//--- txLtssmTop.sv
`timescale 1ns/1ns
`default_nettype none

module txLtssmTop import ltssmPkg::*; #(
	parameter int  LaneCount = 16,
	parameter bit  IsUpstream = 1'b0,
	parameter genT MaxGen = 3'd1,
	parameter int  PollingActiveOsCount = 1024,
	parameter int  DetectTimeoutCycles = 300000  // 12 ms at 25 MHz Pclk
) (
	input  logic                 Pclk,
	input  logic                 rstN,
	input  txStateT              SetTXState,
	output logic                 TXFinishFlag,
	output txStateT              TXExitTo,
	output logic [LaneCount-1:0] DetectLanes,
	output logic [4:0]           NumberDetectLanes,
	output logic                 WriteDetectLanesFlag,
	output linkNumT              WriteLinkNum,
	output logic                 WriteLinkNumFlag,
	input  linkNumT              ReadLinkNum,
	input  logic [LaneCount-1:0] DetectStatus,
	input  logic                 OSGeneratorBusy,
	input  logic                 OSGeneratorFinish,
	input  logic                 startSend16,
	output osTypeT               OSType,
	output linkNumT              LinkNumber,
	output laneNumT              LaneNumber,
	output genT                  Rate,
	output logic                 OSGeneratorStart,
	output logic                 HoldFIFOData,
	output logic                 MuxSel,
	output logic                 ScramblerOff,
	output logic [LaneCount-1:0] DetectReq,
	output logic [LaneCount-1:0] ElecIdleReq
);

	ltssmCtrlIf ctrl ();

	stateTracker #(
		.LaneCount(LaneCount),
		.PollingActiveOsCount(PollingActiveOsCount)
	) tracker (
		.Pclk(Pclk),
		.rstN(rstN),
		.SetTXState(SetTXState),
		.DetectStatus(DetectStatus),
		.OSGeneratorFinish(OSGeneratorFinish),
		.ctrl(ctrl.tracker),
		.TXFinishFlag(TXFinishFlag),
		.TXExitTo(TXExitTo),
		.DetectLanes(DetectLanes),
		.NumberDetectLanes(NumberDetectLanes),
		.WriteDetectLanesFlag(WriteDetectLanesFlag)
	);

	osCounter counter (
		.Pclk(Pclk),
		.rstN(rstN),
		.OSGeneratorFinish(OSGeneratorFinish),
		.startSend16(startSend16),
		.ctrl(ctrl.counter)
	);

	intervalTimer #(
		.DetectTimeoutCycles(DetectTimeoutCycles)
	) detectTimer (
		.Pclk(Pclk),
		.rstN(rstN),
		.ctrl(ctrl.timer)
	);

	osRequester #(
		.LaneCount(LaneCount),
		.IsUpstream(IsUpstream),
		.MaxGen(MaxGen)
	) requester (
		.Pclk(Pclk),
		.rstN(rstN),
		.ReadLinkNum(ReadLinkNum),
		.OSGeneratorBusy(OSGeneratorBusy),
		.ctrl(ctrl.requester),
		.OSType(OSType),
		.LinkNumber(LinkNumber),
		.LaneNumber(LaneNumber),
		.Rate(Rate),
		.OSGeneratorStart(OSGeneratorStart),
		.WriteLinkNum(WriteLinkNum),
		.WriteLinkNumFlag(WriteLinkNumFlag),
		.HoldFIFOData(HoldFIFOData),
		.MuxSel(MuxSel),
		.ScramblerOff(ScramblerOff),
		.DetectReq(DetectReq),
		.ElecIdleReq(ElecIdleReq)
	);

endmodule

`default_nettype wire

//--- tbClockGen.sv
`timescale 1ns/1ns
`default_nettype none

module tbClockGen #(
	parameter int PeriodNs = 40
) (
	output logic Pclk
);

	initial begin
		Pclk = 1'b0;
		forever #(PeriodNs / 2) Pclk = ~Pclk;  // 25 MHz
	end

endmodule

`default_nettype wire

//--- tbTxLtssm.sv
`timescale 1ns/1ns
`default_nettype none

module tbTxLtssm import ltssmPkg::*; ();

	localparam int LaneCount = 16;
	localparam int PollingActiveOsCount = 24;
	localparam int PollingCfgTs2 = 16;     // TS2 sets to leave polling configuration
	localparam int ConfigIdleSets = 7;     // Idle sets after startSend16
	localparam int RecoveryIdleSets = 6;
	localparam int FinishTimeout = 5000;
	localparam linkNumT TestLinkNum = 8'h3C;  // Returned by the main LTSSM
	localparam genT TestMaxGen = 3'd2;        // Gen2 rate code
	localparam logic [LaneCount-1:0] AllLanes = '1;

	logic Pclk;
	logic rstN;
	txStateT SetTXState;
	logic TXFinishFlag;
	txStateT TXExitTo;
	logic [LaneCount-1:0] DetectLanes;
	logic [4:0] NumberDetectLanes;
	logic WriteDetectLanesFlag;
	linkNumT WriteLinkNum;
	logic WriteLinkNumFlag;
	linkNumT ReadLinkNum;
	logic [LaneCount-1:0] DetectStatus;
	logic OSGeneratorBusy;
	logic OSGeneratorFinish;
	logic startSend16;
	osTypeT OSType;
	linkNumT LinkNumber;
	laneNumT LaneNumber;
	genT Rate;
	logic OSGeneratorStart;
	logic HoldFIFOData;
	logic MuxSel;
	logic ScramblerOff;
	logic [LaneCount-1:0] DetectReq;
	logic [LaneCount-1:0] ElecIdleReq;

	// Stimulus table, one row per step
	txStateT stepState [0:31];
	logic [LaneCount-1:0] stepStatus [0:31];
	logic stepSend16 [0:31];
	txStateT stepExit [0:31];   // IdleHold where no finish is expected
	logic [4:0] stepLanes [0:31];
	int stepDwell [0:31];       // Cycles to hold a state with no exit, else 0
	int stepCount;

	logic [31:0] rngState = 32'd74;
	int busyLeft;

	tbClockGen #(.PeriodNs(40)) clockGen (.Pclk(Pclk));

	txLtssmTop #(
		.LaneCount(LaneCount),
		.IsUpstream(1'b0),
		.MaxGen(TestMaxGen),
		.PollingActiveOsCount(PollingActiveOsCount),
		.DetectTimeoutCycles(60)
	) UUT (
		.Pclk(Pclk),
		.rstN(rstN),
		.SetTXState(SetTXState),
		.TXFinishFlag(TXFinishFlag),
		.TXExitTo(TXExitTo),
		.DetectLanes(DetectLanes),
		.NumberDetectLanes(NumberDetectLanes),
		.WriteDetectLanesFlag(WriteDetectLanesFlag),
		.WriteLinkNum(WriteLinkNum),
		.WriteLinkNumFlag(WriteLinkNumFlag),
		.ReadLinkNum(ReadLinkNum),
		.DetectStatus(DetectStatus),
		.OSGeneratorBusy(OSGeneratorBusy),
		.OSGeneratorFinish(OSGeneratorFinish),
		.startSend16(startSend16),
		.OSType(OSType),
		.LinkNumber(LinkNumber),
		.LaneNumber(LaneNumber),
		.Rate(Rate),
		.OSGeneratorStart(OSGeneratorStart),
		.HoldFIFOData(HoldFIFOData),
		.MuxSel(MuxSel),
		.ScramblerOff(ScramblerOff),
		.DetectReq(DetectReq),
		.ElecIdleReq(ElecIdleReq)
	);

	function automatic logic [31:0] nextRandom(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Generator model, busy for 1 to 4 cycles then a finish pulse
	always @(posedge Pclk) begin
		OSGeneratorFinish <= 1'b0;
		if (!rstN) begin
			OSGeneratorBusy <= 1'b0;
			busyLeft = 0;
		end else if (busyLeft > 0) begin
			busyLeft = busyLeft - 1;
			if (busyLeft == 0) begin
				OSGeneratorBusy <= 1'b0;
				OSGeneratorFinish <= 1'b1;
			end
		end else if (OSGeneratorStart) begin
			rngState = nextRandom(rngState);
			busyLeft = 1 + rngState[1:0];
			OSGeneratorBusy <= 1'b1;
		end
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			failRun($sformatf("Mismatch at %0t ns: %s is %0h, expected %0h",
				$time, name, actual, expected));
		end
	endtask

	task automatic addStep(input txStateT st, input logic [LaneCount-1:0] status,
		input logic send16, input txStateT exitTo, input logic [4:0] lanes, input int dwell);
		stepState[stepCount] = st;
		stepStatus[stepCount] = status;
		stepSend16[stepCount] = send16;
		stepExit[stepCount] = exitTo;
		stepLanes[stepCount] = lanes;
		stepDwell[stepCount] = dwell;
		stepCount++;
	endtask

	task automatic buildTable();
		stepCount = 0;
		addStep(DetectQuiet, 16'h0000, 1'b0, DetectActive, 5'd0, 0);
		addStep(DetectActive, 16'h0000, 1'b0, DetectQuiet, 5'd0, 0);  // No receiver
		addStep(DetectQuiet, 16'h0000, 1'b0, DetectActive, 5'd0, 0);
		addStep(DetectActive, 16'h000F, 1'b0, PollingActive, 5'd4, 0);  // Lanes 0 to 3
		addStep(PollingActive, 16'h000F, 1'b0, PollingConfiguration, 5'd0, 0);
		addStep(PollingConfiguration, 16'h000F, 1'b0, ConfigLinkWidthStart, 5'd0, 0);
		addStep(ConfigLinkWidthStart, 16'h000F, 1'b0, IdleHold, 5'd0, 20);
		addStep(ConfigLinkWidthAccept, 16'h000F, 1'b0, ConfigLaneNumWait, 5'd0, 0);
		addStep(ConfigLaneNumWait, 16'h000F, 1'b0, IdleHold, 5'd0, 20);
		addStep(ConfigLaneNumActive, 16'h000F, 1'b0, IdleHold, 5'd0, 20);
		addStep(ConfigComplete, 16'h000F, 1'b0, ConfigIdle, 5'd0, 0);
		addStep(ConfigIdle, 16'h000F, 1'b0, IdleHold, 5'd0, 40);  // Idle sets, no exit yet
		addStep(ConfigIdle, 16'h000F, 1'b1, L0, 5'd0, 0);
		addStep(L0, 16'h000F, 1'b0, IdleHold, 5'd0, 20);
		addStep(RecoveryRcvrLock, 16'h000F, 1'b0, RecoveryRcvrCfg, 5'd0, 0);
		addStep(RecoveryRcvrCfg, 16'h000F, 1'b0, RecoveryIdle, 5'd0, 0);
		addStep(RecoveryIdle, 16'h000F, 1'b0, L0, 5'd0, 0);
		addStep(L0, 16'h000F, 1'b0, IdleHold, 5'd0, 20);
	endtask

	function automatic osTypeT expectedKind(input txStateT st);
		case (st)
			PollingConfiguration, ConfigComplete, RecoveryRcvrCfg: return Ts2;
			ConfigIdle, RecoveryIdle: return IdleOs;
			default: return Ts1;
		endcase
	endfunction

	// Fields of a request made in state st
	task automatic checkStart(input txStateT st);
		case (st)
			DetectQuiet, DetectActive, L0: begin
				failRun("Ordered set requested in a state that sends none");
			end
			default: checkValue("OSType", OSType, expectedKind(st));
		endcase
		case (st)
			PollingActive, PollingConfiguration: checkValue("LinkNumber", LinkNumber, 8'd0);
			ConfigLinkWidthStart: checkValue("LinkNumber", LinkNumber, 8'd1);
			default: checkValue("LinkNumber", LinkNumber, ReadLinkNum);
		endcase
		// Pad until the downstream port numbers the lanes in link-width accept
		case (st)
			PollingActive, PollingConfiguration, ConfigLinkWidthStart: begin
				checkValue("LaneNumber", LaneNumber, 2'd0);
			end
			default: checkValue("LaneNumber", LaneNumber, 2'd1);
		endcase
		checkValue("Rate", Rate, TestMaxGen);
	endtask

	task automatic checkControls(input txStateT st);
		case (st)
			DetectQuiet, RecoveryIdle: checkValue("ElecIdleReq", ElecIdleReq, AllLanes);
			DetectActive: checkValue("DetectReq", DetectReq, AllLanes);
			ConfigIdle: checkValue("ScramblerOff", ScramblerOff, 1'b0);
			L0: begin
				checkValue("HoldFIFOData", HoldFIFOData, 1'b0);
				checkValue("MuxSel", MuxSel, 1'b1);
				checkValue("ScramblerOff", ScramblerOff, 1'b0);
			end
			default: ;
		endcase
		if (st != L0) begin
			checkValue("HoldFIFOData", HoldFIFOData, 1'b1);
		end
	endtask

	task automatic runStep(input int idx);
		txStateT st;
		int cycle;
		int limit;
		int starts;
		int finishes;
		int lanePulses;
		int linkPulses;
		bit flagSeen;
		st = stepState[idx];
		limit = (stepDwell[idx] > 0) ? stepDwell[idx] : FinishTimeout;
		cycle = 0;
		starts = 0;
		finishes = 0;
		lanePulses = 0;
		linkPulses = 0;
		flagSeen = 1'b0;
		@(posedge Pclk);
		SetTXState <= st;
		DetectStatus <= stepStatus[idx];
		startSend16 <= stepSend16[idx];
		// Flag and exit code of the previous state linger for two cycles
		while (!flagSeen && cycle < limit) begin
			@(negedge Pclk);
			cycle++;
			if (OSGeneratorStart && OSGeneratorBusy) begin
				failRun("OSGeneratorStart was raised while OSGeneratorBusy was high");
			end
			if (OSGeneratorFinish) finishes++;
			if (WriteDetectLanesFlag) lanePulses++;
			if (WriteLinkNumFlag) begin
				linkPulses++;
				checkValue("WriteLinkNum", WriteLinkNum, 8'd1);
			end
			if (OSGeneratorStart && cycle >= 3) begin
				starts++;
				checkStart(st);
			end
			if (cycle >= 4) checkControls(st);  // Registered controls settled
			if (TXFinishFlag && cycle >= 3) flagSeen = 1'b1;
		end
		if (stepDwell[idx] > 0) begin
			if (flagSeen) begin
				failRun($sformatf("Step %0d raised TXFinishFlag in state %0d with no exit due",
					idx, st));
			end
		end else begin
			if (!flagSeen) begin
				failRun($sformatf("Step %0d saw no TXFinishFlag within %0d cycles in state %0d",
					idx, FinishTimeout, st));
			end
			checkValue("TXExitTo", TXExitTo, stepExit[idx]);
		end
		case (st)
			DetectActive: begin
				if (stepExit[idx] == PollingActive) begin
					checkValue("WriteDetectLanesFlag pulses", lanePulses, 1);
					checkValue("DetectLanes", DetectLanes, stepStatus[idx]);
					checkValue("NumberDetectLanes", NumberDetectLanes, stepLanes[idx]);
				end else begin
					checkValue("WriteDetectLanesFlag pulses", lanePulses, 0);
				end
			end
			PollingActive: if (starts < PollingActiveOsCount) begin
				failRun("Fewer TS1 requests than needed before leaving polling active");
			end
			PollingConfiguration: if (starts < PollingCfgTs2) begin
				failRun("Fewer TS2 requests than needed before leaving polling configuration");
			end
			ConfigLinkWidthStart: checkValue("WriteLinkNumFlag pulses", linkPulses, 1);
			ConfigIdle: if (stepSend16[idx] && finishes < ConfigIdleSets) begin
				failRun("ConfigIdle exited before seven idle sets finished");
			end
			RecoveryIdle: if (finishes < RecoveryIdleSets) begin
				failRun("RecoveryIdle exited before six idle sets finished");
			end
			default: ;
		endcase
	endtask

	initial begin
		rstN = 1'b0;
		SetTXState = IdleHold;
		DetectStatus = '0;
		startSend16 = 1'b0;
		ReadLinkNum = TestLinkNum;
		OSGeneratorBusy = 1'b0;
		OSGeneratorFinish = 1'b0;
		buildTable();
		repeat (8) @(posedge Pclk);
		rstN <= 1'b1;
		repeat (2) @(posedge Pclk);
		for (int i = 0; i < stepCount; i++) begin
			runStep(i);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
ltssmPkg.sv
ltssmCtrlIf.sv
intervalTimer.sv
osCounter.sv
stateTracker.sv
osRequester.sv
txLtssmTop.sv
tbClockGen.sv
tbTxLtssm.sv

//--- Bender.yml
package:
  name: txLtssm

sources:
  - ltssmPkg.sv
  - ltssmCtrlIf.sv
  - intervalTimer.sv
  - osCounter.sv
  - stateTracker.sv
  - osRequester.sv
  - txLtssmTop.sv
  - target: test
    files:
      - tbClockGen.sv
      - tbTxLtssm.sv
